// File: verilog/fp_fmt_pkg.sv
// Floating-point format package with format enum, widths, lane layout and canonical NaNs
`default_nettype none

package fp_fmt_pkg;

  // ----------------------------------------------------------
  // Datapath geometry
  // ----------------------------------------------------------
  localparam int unsigned WIDTH       = 32;
  localparam int unsigned NUM_FORMATS = 3;

  typedef logic [WIDTH-1:0] word_t;  // Full operand or result word
  typedef logic [7:0]       lane_t;  // Narrowest format, step of the lane offsets

  localparam int unsigned NUM_LANES = WIDTH / $bits(lane_t);

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2   // 1 sign, 5 exponent, 2 mantissa bits
  } fp_fmt_e;

  // One bit per format, indexed by the fp_fmt_e value
  typedef logic [NUM_FORMATS-1:0] fmt_mask_t;

  // ----------------------------------------------------------
  // Per-format tables
  // ----------------------------------------------------------
  localparam int unsigned FMT_WIDTH    [NUM_FORMATS] = '{32, 16, 8};
  localparam int unsigned FMT_EXP_BITS [NUM_FORMATS] = '{8, 5, 5};

  // Quiet NaN with only the top mantissa bit set
  localparam word_t CANON_NAN [NUM_FORMATS] = '{
    32'h7fc0_0000,
    32'h0000_7e00,
    32'h0000_007e
  };

  // Formats that fit in each lane slot
  localparam fmt_mask_t LANE_FORMATS [NUM_LANES] = '{
    3'b111,  // Lane 0 holds every format
    3'b110,  // FP16 and FP8
    3'b100,
    3'b100
  };

  // Width of a format, full word for unknown encodings
  function automatic int unsigned fmt_width(fp_fmt_e fmt);
    if (int'(fmt) < int'(NUM_FORMATS)) begin
      return FMT_WIDTH[int'(fmt)];
    end
    return WIDTH;
  endfunction

endpackage

`default_nettype wire

// File: verilog/fp_op_pkg.sv
// Operation package with op enum, status flags, tag type and slice request/response structs
`default_nettype none

package fp_op_pkg;

  localparam int unsigned TAG_WIDTH = 4;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } nc_op_e;

  // IEEE exception flags in RISC-V fflags order
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  typedef struct packed {
    fp_fmt_pkg::word_t   a;
    fp_fmt_pkg::word_t   b;
    nc_op_e              op;
    fp_fmt_pkg::fp_fmt_e fmt;
    logic                vectorial;  // Use all lanes that fit the format
    tag_t                tag;
  } slice_req_t;

  typedef struct packed {
    fp_fmt_pkg::word_t result;
    fp_status_t        status;
    tag_t              tag;
  } slice_rsp_t;

endpackage

`default_nettype wire

// File: verilog/nc_lane.sv
// Single lane unit for sign injection and min/max over the formats of its slot
`timescale 1ns/1ns
`default_nettype none

module nc_lane #(
  parameter fp_fmt_pkg::fmt_mask_t LaneFormats = '1
) (
  input  fp_fmt_pkg::word_t     a_i,
  input  fp_fmt_pkg::word_t     b_i,
  input  fp_op_pkg::nc_op_e     op_i,
  input  fp_fmt_pkg::fp_fmt_e   fmt_i,
  output fp_fmt_pkg::word_t     result_o,
  output fp_op_pkg::fp_status_t status_o
);
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  word_t      fmt_result [NUM_FORMATS];
  fp_status_t fmt_status [NUM_FORMATS];
  logic       is_minmax;
  logic       is_max;

  assign is_minmax = (op_i == FMIN) || (op_i == FMAX);
  assign is_max    = (op_i == FMAX);

  // ----------------------------------------------------------
  // One datapath per format present in this lane
  // ----------------------------------------------------------
  for (genvar f = 0; f < int'(NUM_FORMATS); f++) begin : gen_fmt
    localparam int unsigned FW       = FMT_WIDTH[f];
    localparam int unsigned EW       = FMT_EXP_BITS[f];
    localparam int unsigned MW       = FW - 1 - EW;
    localparam word_t       NAN_WORD = CANON_NAN[f];

    if (LaneFormats[f]) begin : gen_on
      logic [FW-1:0] a;
      logic [FW-1:0] b;
      logic [FW-1:0] sgnj_res;
      logic [FW-1:0] minmax_res;
      logic          res_sign;
      logic          a_nan;
      logic          b_nan;
      logic          a_snan;
      logic          b_snan;
      logic          a_lt_b;

      assign a = a_i[FW-1:0];
      assign b = b_i[FW-1:0];

      // Exponent all ones with a nonzero mantissa
      assign a_nan  = (&a[FW-2 -: EW]) && (|a[MW-1:0]);
      assign b_nan  = (&b[FW-2 -: EW]) && (|b[MW-1:0]);
      assign a_snan = a_nan && !a[MW-1];  // Quiet bit clear
      assign b_snan = b_nan && !b[MW-1];

      always_comb begin : sign_inject
        case (op_i)
          SGNJN:   res_sign = ~b[FW-1];
          SGNJX:   res_sign = a[FW-1] ^ b[FW-1];
          default: res_sign = b[FW-1];
        endcase
      end

      assign sgnj_res = {res_sign, a[FW-2:0]};  // Magnitude of a

      // Sign-magnitude compare, -0 orders below +0
      assign a_lt_b = (a[FW-1] != b[FW-1]) ? a[FW-1] :
                      a[FW-1]              ? (a[FW-2:0] > b[FW-2:0]) :
                                             (a[FW-2:0] < b[FW-2:0]);

      always_comb begin : min_max
        if (a_nan && b_nan) begin
          minmax_res = NAN_WORD[FW-1:0];
        end else if (a_nan) begin
          minmax_res = b;
        end else if (b_nan) begin
          minmax_res = a;
        end else if (a_lt_b ^ is_max) begin
          minmax_res = a;
        end else begin
          minmax_res = b;
        end
      end

      assign fmt_result[f] = word_t'(is_minmax ? minmax_res : sgnj_res);
      assign fmt_status[f] = '{nv: is_minmax && (a_snan || b_snan),
                               dz: 1'b0, of: 1'b0, uf: 1'b0, nx: 1'b0};
    end else begin : gen_off
      assign fmt_result[f] = '0;  // Format does not fit this slot
      assign fmt_status[f] = '0;
    end
  end

  // Pick the datapath of the requested format
  always_comb begin : fmt_select
    result_o = '0;
    status_o = '0;
    for (int f = 0; f < int'(NUM_FORMATS); f++) begin
      if (fmt_i == fp_fmt_e'(f)) begin
        result_o = fmt_result[f];
        status_o = fmt_status[f];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/nc_result_packer.sv
// Result packer with lane activity, NaN-boxed packing and status collapse
`timescale 1ns/1ns
`default_nettype none

module nc_result_packer (
  input  fp_fmt_pkg::word_t     [fp_fmt_pkg::NUM_LANES-1:0] lane_results_i,
  input  fp_op_pkg::fp_status_t [fp_fmt_pkg::NUM_LANES-1:0] lane_status_i,
  input  fp_fmt_pkg::fp_fmt_e                               fmt_i,
  input  logic                                              vectorial_i,
  input  fp_op_pkg::tag_t                                   tag_i,
  output fp_op_pkg::slice_rsp_t                             rsp_o
);
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  int unsigned          slot_width;
  word_t                slot_mask;
  logic [NUM_LANES-1:0] lane_active;
  word_t                packed_res;
  fp_status_t           status_or;

  assign slot_width = fmt_width(fmt_i);
  assign slot_mask  = (slot_width >= WIDTH) ? '1 : ((word_t'(1) << slot_width) - word_t'(1));

  // ----------------------------------------------------------
  // Lane activity
  // ----------------------------------------------------------
  always_comb begin : lane_activity
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      // Upper lanes only for vectors, and only where the slot fits the word
      lane_active[l] = (l == 0) || (vectorial_i && ((l + 1) * slot_width <= WIDTH));
    end
  end

  // ----------------------------------------------------------
  // Packing and status
  // ----------------------------------------------------------
  always_comb begin : pack
    packed_res = '1;  // Everything not written stays NaN-boxed
    status_or  = '0;
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      if (lane_active[l]) begin
        packed_res &= ~(slot_mask << (l * slot_width));
        packed_res |= (lane_results_i[l] & slot_mask) << (l * slot_width);
        status_or  |= lane_status_i[l];  // Inactive lanes never raise flags
      end
    end
  end

  assign rsp_o = '{result: packed_res, status: status_or, tag: tag_i};

endmodule

`default_nettype wire

// File: verilog/nc_pipe.sv
// Valid/ready register pipeline with synchronous flush and busy indication
`timescale 1ns/1ns
`default_nettype none

module nc_pipe #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  fp_op_pkg::slice_rsp_t data_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  output fp_op_pkg::slice_rsp_t data_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);
  import fp_op_pkg::*;

  // Index i is the signal after i register stages
  slice_rsp_t           stage_data [NumPipeRegs+1];
  logic [NumPipeRegs:0] stage_valid;
  logic [NumPipeRegs:0] stage_ready;

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < int'(NumPipeRegs); i++) begin : gen_stage
    logic       valid_q;
    slice_rsp_t data_q;
    logic       load;

    // Advance when the next stage takes our item or holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
      if (!arst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;  // Drop everything in flight
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  // Output side, ready comes from downstream
  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o               = stage_ready[0];
  assign data_o                   = stage_data[NumPipeRegs];
  assign out_valid_o              = stage_valid[NumPipeRegs];

  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o |= stage_valid[i];
    end
  end

endmodule

`default_nettype wire

// File: verilog/noncomp_multifmt_slice.sv
// Top level of the non-computational slice with operand slicing, lanes, packer and pipeline
`timescale 1ns/1ns
`default_nettype none

module noncomp_multifmt_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Request side
  input  fp_op_pkg::slice_req_t req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  // Response side
  output fp_op_pkg::slice_rsp_t rsp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  int unsigned                slot_width;
  word_t      [NUM_LANES-1:0] lane_results;
  fp_status_t [NUM_LANES-1:0] lane_status;
  slice_rsp_t                 packed_rsp;

  assign slot_width = fmt_width(req_i.fmt);  // Lane offset step for this request

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  for (genvar l = 0; l < int'(NUM_LANES); l++) begin : gen_lanes
    localparam fmt_mask_t LANE_FMTS = LANE_FORMATS[l];

    word_t lane_a;
    word_t lane_b;

    // Upper bits above the slot are ignored inside the lane
    assign lane_a = req_i.a >> (l * slot_width);
    assign lane_b = req_i.b >> (l * slot_width);

    nc_lane #(
      .LaneFormats ( LANE_FMTS )
    ) i_nc_lane (
      .a_i      ( lane_a          ),
      .b_i      ( lane_b          ),
      .op_i     ( req_i.op        ),
      .fmt_i    ( req_i.fmt       ),
      .result_o ( lane_results[l] ),
      .status_o ( lane_status[l]  )
    );
  end

  // ----------------------------------------------------------
  // Packing and output pipeline
  // ----------------------------------------------------------
  nc_result_packer i_nc_result_packer (
    .lane_results_i ( lane_results    ),
    .lane_status_i  ( lane_status     ),
    .fmt_i          ( req_i.fmt       ),
    .vectorial_i    ( req_i.vectorial ),
    .tag_i          ( req_i.tag       ),
    .rsp_o          ( packed_rsp      )
  );

  // All lanes share one pipeline, they always travel together
  nc_pipe #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_nc_pipe (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .data_i      ( packed_rsp  ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .data_o      ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

endmodule

`default_nettype wire

// File: sim/noncomp_multifmt_slice_asserts.sv
// Handshake, stall stability and flush assertions for the slice top level
`timescale 1ns/1ns
`default_nettype none

module noncomp_multifmt_slice_asserts (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  flush_i,
  input fp_op_pkg::slice_rsp_t rsp_i,
  input logic                  out_valid_i,
  input logic                  out_ready_i,
  input logic                  busy_i
);

  // ----------------------------------------------------------
  // Properties
  // ----------------------------------------------------------
  property p_no_valid_in_reset;
    @(posedge clk_i) !arst_n_i |-> !out_valid_i;
  endproperty

  // A stalled response must hold its value until consumed
  property p_stable_under_stall;
    @(posedge clk_i) disable iff (!arst_n_i)
      (out_valid_i && !out_ready_i && !flush_i) |=> (rsp_i == $past(rsp_i));
  endproperty

  property p_idle_after_flush;
    @(posedge clk_i) disable iff (!arst_n_i) flush_i |=> !busy_i;
  endproperty

  a_no_valid_in_reset: assert property (p_no_valid_in_reset)
    else $error("out_valid_o is high while reset is asserted");
  a_stable_under_stall: assert property (p_stable_under_stall)
    else $error("rsp_o changed while the output was stalled");
  a_idle_after_flush: assert property (p_idle_after_flush)
    else $error("busy_o still high one cycle after a flush");

endmodule

`default_nettype wire

// File: sim/noncomp_multifmt_slice_tb.sv
// Testbench for the slice top level with vector file stimulus, stall generator, flush and reset tests
`timescale 1ns/1ns
`default_nettype none

module noncomp_multifmt_slice_tb;
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  localparam int unsigned MAX_VEC = 64;

  typedef logic [8*24-1:0] name_t;  // Test name as read from the vector file

  logic       clk_i;
  logic       arst_n_i;
  slice_req_t req_i;
  logic       in_valid_i;
  logic       in_ready_o;
  logic       flush_i;
  slice_rsp_t rsp_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  name_t       vec_name [MAX_VEC];
  slice_req_t  vec_req  [MAX_VEC];
  word_t       vec_res  [MAX_VEC];
  fp_status_t  vec_st   [MAX_VEC];
  int unsigned num_vec;
  int unsigned exp_q [$];  // Indices of accepted requests in arrival order

  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;
  logic [31:0] lcg_state   = 32'h655d_0710;

  noncomp_multifmt_slice #(
    .NumPipeRegs ( 2 )
  ) dut_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  bind noncomp_multifmt_slice noncomp_multifmt_slice_asserts i_asserts (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .flush_i     ( flush_i     ),
    .rsp_i       ( rsp_o       ),
    .out_valid_i ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_i      ( busy_o      )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic stop_on_error();
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_result(input name_t name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Fail %0s: result expected %08h, actual %08h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_status(input name_t name, input fp_status_t exp, input fp_status_t act);
    if (act !== exp) begin
      $display("Fail %0s: status expected %02h, actual %02h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_tag(input name_t name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      $display("Fail %0s: tag expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input name_t name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %0s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  // Vector file columns are name op fmt vectorial a b tag result status in hex
  task automatic load_vectors();
    int          fd;
    int          code;
    string       line;
    name_t       name;
    slice_req_t  req;
    logic [31:0] op_v, fmt_v, vec_v, a_v, b_v, tag_v, res_v, st_v;
    fd = $fopen("sim/slice_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/slice_vectors.txt");
      stop_on_error();
    end
    num_vec = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 4 || line.getc(0) == "#") continue;  // Comments and blank lines
      code = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                     name, op_v, fmt_v, vec_v, a_v, b_v, tag_v, res_v, st_v);
      if (code != 9 || num_vec >= MAX_VEC) begin
        $display("Malformed or excess line in the vector file: %0s", line);
        stop_on_error();
      end
      req           = '0;
      req.a         = a_v;
      req.b         = b_v;
      req.op        = nc_op_e'(op_v[2:0]);
      req.fmt       = fp_fmt_e'(fmt_v[1:0]);
      req.vectorial = vec_v[0];
      req.tag       = tag_v[3:0];
      vec_name[num_vec] = name;
      vec_req[num_vec]  = req;
      vec_res[num_vec]  = res_v;
      vec_st[num_vec]   = st_v[4:0];
      num_vec++;
    end
    $fclose(fd);
    if (num_vec == 0) begin
      $display("The vector file holds no test vectors");
      stop_on_error();
    end
  endtask

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      stop_on_error();
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin : main
    int unsigned sent;
    int unsigned idx;
    logic [31:0] rnd;
    arst_n_i    = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    flush_i     = 1'b0;
    load_vectors();
    cycle_limit = num_vec * 20 + 100;

    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_bit("reset out_valid", 1'b0, out_valid_o);
    check_bit("reset busy", 1'b0, busy_o);
    check_bit("reset in_ready", 1'b1, in_ready_o);

    // Stream all vectors with random output stalls
    sent = 0;
    while (sent < num_vec || exp_q.size() != 0) begin
      @(posedge clk_i);
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(sent);
        sent++;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived with no request in flight");
          stop_on_error();
        end
        idx = exp_q.pop_front();
        check_result(vec_name[idx], vec_res[idx], rsp_o.result);
        check_status(vec_name[idx], vec_st[idx], rsp_o.status);
        check_tag(vec_name[idx], vec_req[idx].tag, rsp_o.tag);
      end
      in_valid_i <= (sent < num_vec);
      if (sent < num_vec) req_i <= vec_req[sent];
      rnd = lcg_next();
      out_ready_i <= (rnd[31:30] != 2'b00);  // Ready three cycles in four
    end

    // Fill both stages while stalled and flush them
    out_ready_i <= 1'b0;
    in_valid_i  <= 1'b1;
    req_i       <= vec_req[0];
    sent = 0;
    while (sent < 2) begin
      @(posedge clk_i);
      if (in_valid_i && in_ready_o) sent++;
      if (sent < 2) req_i <= vec_req[sent];
    end
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(negedge clk_i);
    check_bit("flush busy before", 1'b1, busy_o);
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    check_bit("flush busy after", 1'b0, busy_o);
    check_bit("flush in_ready", 1'b1, in_ready_o);
    repeat (4) begin
      @(posedge clk_i);
      if (out_valid_o) begin
        $display("A flushed item appeared at the output");
        stop_on_error();
      end
      out_ready_i <= 1'b1;
    end

    // Reset while both stages hold items
    out_ready_i <= 1'b0;
    in_valid_i  <= 1'b1;
    req_i       <= vec_req[0];
    sent = 0;
    while (sent < 2) begin
      @(posedge clk_i);
      if (in_valid_i && in_ready_o) sent++;
    end
    in_valid_i <= 1'b0;
    @(negedge clk_i);
    check_bit("busy before reset", 1'b1, busy_o);
    @(posedge clk_i);
    arst_n_i <= 1'b0;
    @(negedge clk_i);
    check_bit("reset in flight valid", 1'b0, out_valid_o);
    check_bit("reset in flight busy", 1'b0, busy_o);
    check_bit("reset in flight ready", 1'b1, in_ready_o);
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/slice_vectors.txt
# name op fmt vectorial a b tag result status (hex; op 0..4 = SGNJ SGNJN SGNJX FMIN FMAX)
# fmt 0..2 = FP32 FP16 FP8; status bit 4 is nv
sgnj_fp32          0 0 0 3f800000 c0000000 0 bf800000 00
sgnjn_fp32         1 0 0 3f800000 c0000000 1 3f800000 00
sgnjx_fp32         2 0 0 bf800000 c0000000 2 3f800000 00
sgnj_fp16          0 1 0 12343c00 0000c000 3 ffffbc00 00
sgnjn_fp16         1 1 0 abcd3c00 0000c000 4 ffff3c00 00
sgnjx_fp16         2 1 0 5555bc00 0000c000 5 ffff3c00 00
sgnj_fp8           0 2 0 1234563c 000000c0 6 ffffffbc 00
sgnjn_fp8          1 2 0 0000003c 00000040 7 ffffffbc 00
sgnjx_fp8          2 2 0 000000bc 000000c0 8 ffffff3c 00
vec_sgnj_fp16      0 1 1 3c004000 80000000 9 bc004000 00
vec_sgnjx_fp16     2 1 1 bc003c00 80008000 a 3c00bc00 00
vec_sgnjn_fp8      1 2 1 3c3c3c3c 00800080 b bc3cbc3c 00
vec_sgnj_fp8       0 2 1 01020304 80008000 c 81028304 00
vec_sgnj_fp32      0 0 1 3f800000 c0000000 d bf800000 00
fmin_zeros_fp32    3 0 0 00000000 80000000 e 80000000 00
fmax_zeros_fp32    4 0 0 80000000 00000000 f 00000000 00
fmin_num_fp32      3 0 0 3f800000 40000000 0 3f800000 00
fmax_neg_fp32      4 0 0 bf800000 c0000000 1 bf800000 00
fmin_qnan_fp32     3 0 0 7fc00000 3f800000 2 3f800000 00
fmax_2qnan_fp32    4 0 0 7fc00001 ffc00000 3 7fc00000 00
fmin_snan_fp32     3 0 0 7f800001 40000000 4 40000000 10
fmax_2snan_fp32    4 0 0 7f800001 ff800002 5 7fc00000 10
sgnj_snan_fp32     0 0 0 7f800001 80000000 6 ff800001 00
fmin_zeros_fp16    3 1 0 00008000 00000000 7 ffff8000 00
fmax_qnan_fp16     4 1 0 00007e00 0000c000 8 ffffc000 00
fmin_2nan_fp16     3 1 0 00007c01 00007e00 9 ffff7e00 10
vec_fmax_fp16      4 1 1 4000bc00 3c00c000 a 4000bc00 00
vec_fmin_snan_fp16 3 1 1 7c013c00 00004000 b 00003c00 10
fmin_upsnan_fp16   3 1 0 7c013c00 00004000 c ffff3c00 00
vec_fmin_fp8       3 2 1 3cc07e00 403c3c80 d 3cc03c80 00
vec_fmax_snan_fp8  4 2 1 007d003c 007e0040 e 007e0040 10
fmin_upsnan_fp8    3 2 0 7d000040 00000044 f ffffff40 00
fmax_qnan_fp8      4 2 0 0000007e 000000bc 0 ffffffbc 00

// File: noncomp_multifmt_slice.f
verilog/fp_fmt_pkg.sv
verilog/fp_op_pkg.sv
verilog/nc_lane.sv
verilog/nc_result_packer.sv
verilog/nc_pipe.sv
verilog/noncomp_multifmt_slice.sv
sim/noncomp_multifmt_slice_asserts.sv
sim/noncomp_multifmt_slice_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the slice testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f noncomp_multifmt_slice.f \
  --top-module noncomp_multifmt_slice_tb -o slice_tb \
  && ./obj_dir/slice_tb | tee /dev/stderr | grep -q "All tests passed!" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
